//--- project.f
+incdir+common
common/chiplet_pkg.sv
common/tx_fsm_if.sv
common/endpoint_if.sv
tx_fsm/crc32_unit.sv
tx_fsm/tx_fsm.sv
hw/tx_regs.sv
hw/flit_fifo.sv
hw/chiplet_tx_top.sv
test/chiplet_tx_sva.sv
test/tb_chiplet_tx.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_chiplet_tx
LINT_TOP   ?= chiplet_tx_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS   ?= +verilator+error+limit+100
PASS_MSG   := PASS: all tests
SOURCES    := $(wildcard common/* hw/* tx_fsm/* test/*)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_chiplet_tx.sv
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tb_chiplet_tx import chiplet_pkg::*; ();
    localparam int          NUM_TESTS = 5;
    localparam int          WATCHDOG  = 10 * 1500 + 5000;   // 10 packets, back-pressured ones slow
    localparam logic [31:0] POLY      = 32'h04C1_1DB7;

    logic        clk = 1'b0;
    logic        n_rst;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        flit_valid;
    logic        flit_ready = 1'b1;
    logic        buffer_available = 1'b0;
    flit_t       flit_data;

    flit_t       exp_q[$];
    node_id_t    node_id;
    logic [31:0] lfsr_stim    = 32'h9b03;
    logic [31:0] lfsr_ready   = 32'h9b03;
    logic        credit_auto  = 1'b1;
    logic        credit_pulse = 1'b0;
    logic        backpress    = 1'b0;
    int          credit_tick  = 0;
    int          rx_cnt       = 0;
    int          err_cnt      = 0;

    chiplet_tx_top dut_i (.*);

    always #50 clk = ~clk;

    // ************************************************************************
    // Helpers
    // ************************************************************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic rand_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            st  = lfsr_next(st);
            val = {val[30:0], st[31]};
        end
    endtask

    // Bit serial, MSB first
    function automatic logic [31:0] crc_word(input logic [31:0] crc, input logic [31:0] d);
        logic [31:0] c;
        c = crc;
        for (int i = 31; i >= 0; i--) begin
            c = (c[31] ^ d[i]) ? ((c << 1) ^ POLY) : (c << 1);
        end
        return c;
    endfunction

    function automatic flit_t make_flit(input pkt_id_t id, input logic [31:0] payload);
        flit_t f;
        f.metadata.vc  = 1'b0;
        f.metadata.id  = id;
        f.metadata.req = node_id;
        f.payload      = payload;
        return f;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk); while (!(awready && wready));   // Stalls while the FSM is busy
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(posedge clk);
        #1;
        bready = 1'b1;                          // One cycle late, bvalid must hold
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // Queues the expected flits first, then writes CTRL, header and data
    task automatic send_packet(input pkt_id_t id, input format_e fmt, input int n,
                               input logic peek);
        long_hdr_t   hdr;
        logic [31:0] words[$];
        logic [31:0] val;
        logic [31:0] crc;
        logic [1:0]  resp;
        rand_bits(lfsr_stim, 20, val);
        hdr.format    = fmt;
        hdr.opaque    = val[19:0];
        hdr.num_words = 8'(n);
        words.push_back(32'(hdr));
        for (int i = 0; i < n; i++) begin
            rand_bits(lfsr_stim, 32, val);
            words.push_back(val);
        end
        crc = '1;
        foreach (words[i]) begin
            exp_q.push_back(make_flit(id, words[i]));
            crc = crc_word(crc, words[i]);
        end
        if (fmt != FMT_SWITCH_CFG) begin
            exp_q.push_back(make_flit(id, crc));
        end
        axi_write(`CTRL_ADDR, 32'(id), resp);
        if (peek) begin
            axi_read(`STATUS_ADDR, val, resp);
            check_value("STATUS sending bit", 32'(val[0]), 32'd1);
        end
        foreach (words[i]) begin
            axi_write(`TX_SEND_ADDR, words[i], resp);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic set_mode(input logic auto_credit, input logic hold_ready);
        @(negedge clk);
        credit_auto = auto_credit;
        backpress   = hold_ready;
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_credit();
        @(negedge clk);
        credit_pulse = 1'b1;
        @(negedge clk);
        credit_pulse = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %s", num, name, (err_cnt == errs_before) ? "ok" : "errors");
    endtask

    // ************************************************************************
    // Switch side and flit monitor
    // ************************************************************************
    always @(posedge clk) begin
        logic [31:0] gap;
        #1;
        credit_tick++;
        buffer_available = credit_auto ? (credit_tick % 4 == 0) : credit_pulse;
        rand_bits(lfsr_ready, 5, gap);
        flit_ready = !backpress || gap == 0;   // Ready one cycle in 32
    end

    always @(negedge clk) begin
        if (flit_valid && flit_ready) begin
            rx_cnt++;
            assert (exp_q.size() != 0) else begin
                $display("Unexpected flit %h at %0t with nothing queued", flit_data, $time);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                assert (flit_data == exp_q[0]) else begin
                    $display("ERR %0t: flit %h, expected %h", $time, flit_data, exp_q[0]);
                    err_cnt++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG);
        $display("FAIL: see errors above");
        $finish;
    end

    // ************************************************************************
    // Tests
    // ************************************************************************
    initial begin
        logic [31:0] val;
        logic [1:0]  resp;
        int          mark;
        int          base;
        n_rst   = 1'b0;
        awaddr  = '0;
        wdata   = '0;
        wstrb   = '0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        n_rst = 1'b1;
        @(posedge clk);
        #1;

        mark = err_cnt;
        rand_bits(lfsr_stim, 4, val);
        axi_write(`NODE_ADDR, val, resp);
        node_id = node_id_t'(val);
        send_packet(pkt_id_t'(2), FMT_SWITCH_CFG, 0, 1'b0);
        wait_drain();
        end_test(1, "switch config", mark);

        mark = err_cnt;
        for (int i = 0; i < 4; i++) begin
            rand_bits(lfsr_stim, 3, val);
            send_packet(pkt_id_t'(i), format_e'(1 + i % 3), 1 + int'(val % 5), 1'b0);
            wait_drain();
        end
        end_test(2, "long packets", mark);

        mark = err_cnt;
        set_mode(1'b1, 1'b1);
        for (int i = 0; i < 3; i++) begin
            rand_bits(lfsr_stim, 2, val);
            send_packet(pkt_id_t'(i + 1), FMT_LONG_WRITE, 10 + int'(val), 1'b0);
            wait_drain();
        end
        set_mode(1'b1, 1'b0);
        end_test(3, "back-pressure", mark);

        mark = err_cnt;
        set_mode(1'b0, 1'b0);
        pulse_credit();
        base = rx_cnt;
        send_packet(pkt_id_t'(3), FMT_LONG_READ, 5, 1'b0);
        while (rx_cnt < base + 6) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        assert (rx_cnt == base + 6 && exp_q.size() == 1) else begin
            $display("ERR %0t: %0d flits without a credit pulse, expected 6", $time, rx_cnt - base);
            err_cnt++;
        end
        pulse_credit();
        set_mode(1'b1, 1'b0);
        wait_drain();
        end_test(4, "credit", mark);

        mark = err_cnt;
        rand_bits(lfsr_stim, 4, val);
        axi_write(`NODE_ADDR, val, resp);
        node_id = node_id_t'(val);
        check_value("NODE write response", 32'(resp), 32'h0);
        axi_read(`NODE_ADDR, val, resp);
        check_value("node_id readback", val, 32'(node_id));
        send_packet(pkt_id_t'(1), FMT_MEM_RESP, 2, 1'b1);
        wait_drain();
        axi_read(`STATUS_ADDR, val, resp);
        check_value("STATUS after packet", val, 32'h0);
        axi_write(32'h2000, 32'h5a5a, resp);
        check_value("unmapped write response", 32'(resp), 32'h2);
        axi_read(32'h2000, val, resp);
        check_value("unmapped read response", 32'(resp), 32'h2);
        check_value("unmapped read data", val, 32'h0);
        end_test(5, "registers", mark);

        $display("%0d tests, %0d check errors, %0d assertion failures",
                 NUM_TESTS, err_cnt, dut_i.sva_i.fail_cnt);
        if (err_cnt == 0 && dut_i.sva_i.fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- test/chiplet_tx_sva.sv
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module chiplet_tx_sva import chiplet_pkg::*; (
    input logic  clk,
    input logic  n_rst,
    input logic  bvalid,
    input logic  bready,
    input logic  flit_valid,
    input logic  flit_ready,
    input flit_t flit_data,
    input logic  buffer_available,
    input logic  push,
    input logic  full
);
    localparam int CREDIT = 3 * `DEPTH / 4;

    int pushed;        // Pushes since the last credit pulse
    int in_flight;     // In the FIFO or its output register
    int fail_cnt = 0;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pushed    <= 0;
            in_flight <= 0;
        end else begin
            pushed    <= buffer_available ? int'(push) : pushed + int'(push);
            in_flight <= in_flight + int'(push) - int'(flit_valid && flit_ready);
        end
    end

    flit_held: assert property (@(posedge clk) disable iff (!n_rst)
        flit_valid && !flit_ready |=> flit_valid && $stable(flit_data)) else begin
        fail_cnt++;
        $error("flit_data or flit_valid changed while the switch held it");
    end

    bvalid_held: assert property (@(posedge clk) disable iff (!n_rst)
        bvalid && !bready |=> bvalid) else begin
        fail_cnt++;
        $error("bvalid dropped before bready");
    end

    // A push into a full FIFO would be dropped
    push_room: assert property (@(posedge clk) disable iff (!n_rst) push |-> !full) else begin
        fail_cnt++;
        $error("push while the FIFO is full");
    end

    // Any flit still in flight must show at the output
    flits_kept: assert property (@(posedge clk) disable iff (!n_rst)
        in_flight >= 0 && in_flight <= `DEPTH + 1 && flit_valid == (in_flight > 0)) else begin
        fail_cnt++;
        $error("flit_valid disagrees with the flits in flight, a flit was lost or duplicated");
    end

    credit_kept: assert property (@(posedge clk) disable iff (!n_rst) pushed <= CREDIT) else begin
        fail_cnt++;
        $error("more than %0d flits pushed between credit pulses", CREDIT);
    end

endmodule

bind chiplet_tx_top chiplet_tx_sva sva_i (
    .clk(clk), .n_rst(n_rst), .bvalid(bvalid), .bready(bready),
    .flit_valid(flit_valid), .flit_ready(flit_ready), .flit_data(flit_data),
    .buffer_available(buffer_available), .push(ep_if.push), .full(ep_if.full)
);

//--- hw/chiplet_tx_top.sv
`timescale 1ns/1ps

module chiplet_tx_top import chiplet_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    // AXI4-Lite slave
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    // Toward the switch
    output logic        flit_valid,
    input  logic        flit_ready,
    output flit_t       flit_data,
    input  logic        buffer_available
);
    tx_fsm_if   tx_if ();
    endpoint_if ep_if ();

    assign ep_if.buffer_available = buffer_available;

    tx_regs regs_i (
        .clk(clk), .n_rst(n_rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .tx_if(tx_if.regs)
    );

    tx_fsm fsm_i (.clk(clk), .n_rst(n_rst), .tx_if(tx_if.fsm), .ep_if(ep_if.fsm));

    flit_fifo fifo_i (
        .clk(clk), .n_rst(n_rst), .ep_if(ep_if.fifo),
        .flit_valid(flit_valid), .flit_ready(flit_ready), .flit_data(flit_data)
    );

endmodule

//--- hw/flit_fifo.sv
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module flit_fifo import chiplet_pkg::*; (
    input  logic     clk,
    input  logic     n_rst,
    endpoint_if.fifo ep_if,
    output logic     flit_valid,
    input  logic     flit_ready,
    output flit_t    flit_data
);
    localparam int             PTR_W    = $clog2(`DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = `DEPTH;

    flit_t            mem [`DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             out_free, mem_empty, bypass, mem_wr, mem_rd;

    assign out_free   = !flit_valid || flit_ready;   // Output register can load
    assign mem_empty  = count == '0;
    assign bypass     = ep_if.push && mem_empty && out_free;
    assign mem_wr     = ep_if.push && !bypass;
    assign mem_rd     = out_free && !mem_empty;
    assign ep_if.full = count == FULL_CNT;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            flit_valid <= 1'b0;
        end else begin
            if (mem_wr) wr_ptr <= wr_ptr + 1'b1;
            if (mem_rd) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(mem_wr) - (PTR_W+1)'(mem_rd);
            if (out_free) begin
                flit_valid <= !mem_empty || ep_if.push;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= ep_if.flit;
        end
        if (mem_rd) begin
            flit_data <= mem[rd_ptr];     // Oldest entry first
        end else if (bypass) begin
            flit_data <= ep_if.flit;
        end
    end

endmodule

//--- hw/tx_regs.sv
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tx_regs import chiplet_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    tx_fsm_if.regs      tx_if
);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    node_id_t    node_id;
    logic        wr_data_hit;
    logic        wr_accept;
    logic        ar_accept;
    logic [31:0] rd_value;

    function automatic logic is_mapped(input logic [31:0] addr);
        return addr == `CTRL_ADDR || addr == `TX_SEND_ADDR ||
               addr == `NODE_ADDR || addr == `STATUS_ADDR;
    endfunction

    // ************************************************************************
    // Write channel
    // ************************************************************************
    assign wr_data_hit = awaddr == `TX_SEND_ADDR;
    assign wr_accept   = awvalid && wvalid && !bvalid && !(wr_data_hit && tx_if.busy);
    assign awready     = wr_accept;
    assign wready      = wr_accept;

    assign tx_if.start   = wr_accept && awaddr == `CTRL_ADDR;
    assign tx_if.wen     = wr_accept && wr_data_hit;
    assign tx_if.wdata   = wdata;
    assign tx_if.node_id = node_id;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bvalid  <= 1'b0;
            node_id <= '0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wr_accept && awaddr == `NODE_ADDR && wstrb[0]) begin
                node_id <= node_id_t'(wdata);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // ************************************************************************
    // Read channel
    // ************************************************************************
    assign ar_accept = arvalid && !rvalid;
    assign arready   = ar_accept;

    always_comb begin
        case (araddr)
            `NODE_ADDR:   rd_value = 32'(node_id);
            `STATUS_ADDR: rd_value = {30'd0, tx_if.busy, tx_if.sending};
            default:      rd_value = '0;   // Unmapped reads zero too
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rvalid <= 1'b0;
        end else if (ar_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_accept) begin
            rdata <= rd_value;
            rresp <= is_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

//--- tx_fsm/tx_fsm.sv
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tx_fsm import chiplet_pkg::*; (
    input logic     clk,
    input logic     n_rst,
    tx_fsm_if.fsm   tx_if,
    endpoint_if.fsm ep_if
);
    localparam int CREDIT = 3 * `DEPTH / 4;
    localparam int SEND_W = $clog2(CREDIT + 1);

    typedef enum logic [2:0] {
        IDLE, HEADER, CRC, SEND_PKT, SEND_CRC
    } state_e;

    state_e            state, next_state;
    pkt_id_t           pkt_id;
    pkt_len_t          len_left;     // Flits still to push, CRC included
    logic [31:0]       data_store;   // Word waiting on its CRC update
    logic              crc_ok;
    logic [SEND_W-1:0] send_cnt;
    long_hdr_t         hdr;
    flit_t             flit;
    logic              is_cfg, can_push, push, busy;
    logic              crc_clear, crc_update, crc_done;
    logic [31:0]       crc_out;

    crc32_unit crc_i (
        .clk    (clk),
        .n_rst  (n_rst),
        .clear  (crc_clear),
        .update (crc_update),
        .data_in(tx_if.wdata),
        .crc_out(crc_out),
        .done   (crc_done)
    );

    assign hdr        = long_hdr_t'(tx_if.wdata);
    assign is_cfg     = hdr.format == FMT_SWITCH_CFG;
    assign can_push   = !ep_if.full && send_cnt < SEND_W'(CREDIT);
    assign crc_clear  = state == IDLE;
    assign crc_update = tx_if.wen && ((state == HEADER && !is_cfg) || state == SEND_PKT);

    assign tx_if.sending = state != IDLE;
    assign tx_if.busy    = busy;
    assign ep_if.push    = push;
    assign ep_if.flit    = flit;

    always_comb begin
        next_state            = state;
        push                  = 1'b0;
        busy                  = 1'b0;
        flit.metadata.vc      = 1'b0;   // Single VC
        flit.metadata.id      = pkt_id;
        flit.metadata.req     = tx_if.node_id;
        flit.payload          = data_store;

        case (state)
            IDLE: begin
                if (tx_if.start) begin
                    next_state = HEADER;
                end
            end
            HEADER: begin
                busy         = !can_push;   // Switch cfg goes out in the wen cycle
                flit.payload = tx_if.wdata;
                if (tx_if.wen && can_push) begin
                    push       = is_cfg;
                    next_state = is_cfg ? IDLE : CRC;
                end
            end
            CRC: begin
                busy = 1'b1;
                if ((crc_ok || crc_done) && can_push) begin
                    push       = 1'b1;
                    next_state = (len_left == pkt_len_t'(2)) ? SEND_CRC : SEND_PKT;
                end
            end
            SEND_PKT: begin
                if (tx_if.wen) begin
                    next_state = CRC;
                end
            end
            SEND_CRC: begin
                busy         = 1'b1;
                flit.payload = crc_out;
                if (can_push) begin
                    push       = 1'b1;
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= IDLE;
            pkt_id   <= '0;
            len_left <= '0;
            crc_ok   <= 1'b0;
            send_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE && tx_if.start) begin
                pkt_id <= pkt_id_t'(tx_if.wdata);
            end
            if (state == HEADER && crc_update) begin
                len_left <= expected_num_flits(hdr);
            end else if (push && state != HEADER) begin
                len_left <= len_left - pkt_len_t'(1);
            end
            if (push) begin
                crc_ok <= 1'b0;
            end else if (crc_done) begin
                crc_ok <= 1'b1;                  // Credit or FIFO stalled the push
            end
            if (ep_if.buffer_available) begin
                send_cnt <= push ? SEND_W'(1) : '0;
            end else if (push) begin
                send_cnt <= send_cnt + SEND_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (crc_update) begin
            data_store <= tx_if.wdata;
        end
    end

endmodule

//--- tx_fsm/crc32_unit.sv
`timescale 1ns/1ps

module crc32_unit (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        clear,
    input  logic        update,
    input  logic [31:0] data_in,
    output logic [31:0] crc_out,
    output logic        done
);
    localparam logic [31:0] POLY = 32'h04C1_1DB7;

    logic [23:0] rest;        // Bytes not yet folded in
    logic [1:0]  byte_cnt;
    logic        running;
    logic [7:0]  cur_byte;

    // One byte, MSB first, no reflection
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {b, 24'd0};
        for (int i = 0; i < 8; i++) begin
            c = c[31] ? ((c << 1) ^ POLY) : (c << 1);
        end
        return c;
    endfunction

    assign cur_byte = running ? rest[23:16] : data_in[31:24];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_out  <= '1;
            running  <= 1'b0;
            byte_cnt <= '0;
            done     <= 1'b0;
        end else if (clear) begin
            crc_out  <= '1;
            running  <= 1'b0;
            byte_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= running && byte_cnt == 2'd3;
            if (running || update) begin
                crc_out  <= crc_byte(crc_out, cur_byte);
                byte_cnt <= byte_cnt + 2'd1;
                running  <= !(running && byte_cnt == 2'd3);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            rest <= {rest[15:0], 8'd0};
        end else if (update) begin
            rest <= data_in[23:0];
        end
    end

endmodule

//--- common/endpoint_if.sv
`timescale 1ns/1ps

interface endpoint_if import chiplet_pkg::*; ();
    logic  push;
    flit_t flit;
    logic  full;
    logic  buffer_available;     // Credit return from the switch

    modport fsm (
        output push, flit,
        input  full, buffer_available
    );

    modport fifo (
        input  push, flit,
        output full
    );
endinterface

//--- common/tx_fsm_if.sv
`timescale 1ns/1ps

interface tx_fsm_if import chiplet_pkg::*; ();
    logic        start;      // CTRL write, packet id in wdata
    logic        wen;        // TX_DATA write
    logic [31:0] wdata;
    node_id_t    node_id;
    logic        sending;
    logic        busy;       // Hold off TX_DATA writes

    modport regs (
        output start, wen, wdata, node_id,
        input  sending, busy
    );

    modport fsm (
        input  start, wen, wdata, node_id,
        output sending, busy
    );
endinterface

//--- common/chiplet_pkg.sv
`include "chiplet_cfg.svh"

package chiplet_pkg;

    typedef enum logic [3:0] {
        FMT_SWITCH_CFG = 4'h0,
        FMT_LONG_READ  = 4'h1,
        FMT_LONG_WRITE = 4'h2,
        FMT_MEM_RESP   = 4'h3
    } format_e;

    typedef struct packed {
        format_e     format;      // Top nibble
        logic [19:0] opaque;
        logic [7:0]  num_words;   // Data words after the header
    } long_hdr_t;

    typedef logic [$clog2(`NUM_MSGS)-1:0] pkt_id_t;
    typedef logic [`NODE_ID_W-1:0]        node_id_t;
    typedef logic [8:0]                   pkt_len_t;   // 255 words + header + CRC

    typedef struct packed {
        logic     vc;
        pkt_id_t  id;
        node_id_t req;
    } flit_meta_t;

    typedef struct packed {
        flit_meta_t  metadata;
        logic [31:0] payload;
    } flit_t;

    // Total flits the header announces
    function automatic pkt_len_t expected_num_flits(input long_hdr_t hdr);
        if (hdr.format == FMT_SWITCH_CFG) begin
            return pkt_len_t'(1);
        end
        return pkt_len_t'(hdr.num_words) + pkt_len_t'(2);
    endfunction

endpackage

//--- common/chiplet_cfg.svh
`ifndef CHIPLET_CFG_SVH
`define CHIPLET_CFG_SVH

`define NUM_MSGS      4         // Outstanding packet ids
`define DEPTH         8         // Flit FIFO and downstream buffer depth
`define NODE_ID_W     4

// Register map
`define CTRL_ADDR     32'h1000
`define TX_SEND_ADDR  32'h1004
`define NODE_ADDR     32'h1008
`define STATUS_ADDR   32'h100C

`endif
